// File: all.f
src/axi_rd_pkg.sv
src/axil_rd_if.sv
src/sync_fifo_zl.sv
src/axi_axil_reflect_rd.sv
src/axil_rd_mem.sv
src/axi_rd_top.sv
verif/tb_clk_gen.sv
verif/axi_rd_assert.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: rom.hex
// One 16-bit word per line, word index 0 to 31 from the top
C05A
C15B
C258
C359
C45E
C55F
C65C
C75D
C852
C953
CA50
CB51
CC56
CD57
CE54
CF55
D04A
D14B
D248
D349
D44E
D54F
D64C
D74D
D842
D943
DA40
DB41
DC46
DD47
DE44
DF45

// File: run.sh
#!/usr/bin/env bash
# Compile with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f all.f \
  && ./obj_dir/Vtb_top | tee /dev/stderr | grep -x "TEST PASSED" > /dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// File: src/axi_axil_reflect_rd.sv
`timescale 1ns/100ps
`default_nettype none

module axi_axil_reflect_rd #(
  parameter int ADDR_WIDTH       = 8,
  parameter int DATA_WIDTH       = 16,
  parameter int ID_WIDTH         = 4,
  parameter int USER_WIDTH       = 1,
  parameter int OUTSTANDING_BITS = 2
) (
  input  wire logic                  clk,
  input  wire logic                  i_rst,

  // AXI read subordinate side
  input  wire logic                  i_s_arvalid,
  input  wire logic [ID_WIDTH-1:0]   i_s_arid,
  input  wire logic [ADDR_WIDTH-1:0] i_s_araddr,
  input  wire logic [USER_WIDTH-1:0] i_s_aruser,
  output logic                       o_s_arready,
  output logic                       o_s_rvalid,
  output logic [ID_WIDTH-1:0]        o_s_rid,
  output logic [DATA_WIDTH-1:0]      o_s_rdata,
  output logic [1:0]                 o_s_rresp,
  output logic [USER_WIDTH-1:0]      o_s_ruser,
  input  wire logic                  i_s_rready,

  axil_rd_if.mgr                     m_axil
);
  logic ar_ready;
  logic id_ready;
  logic id_valid;
  logic ar_hs;
  logic r_hs;

  assign ar_hs = i_s_arvalid && o_s_arready;
  assign r_hs  = o_s_rvalid && i_s_rready;

  // Address queue toward AXI-Lite, two entries
  sync_fifo_zl #(
    .ADDR_BITS  (1),
    .DATA_WIDTH (ADDR_WIDTH)
  ) u_ar_fifo (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_w_inc     (ar_hs),
    .i_w_data    (i_s_araddr),
    .o_w_full_n  (ar_ready),
    .i_r_inc     (m_axil.arvalid && m_axil.arready),
    .o_r_data    (m_axil.araddr),
    .o_r_empty_n (m_axil.arvalid)
  );

  // ID and user bits, one entry per read in flight
  sync_fifo_zl #(
    .ADDR_BITS  (OUTSTANDING_BITS),
    .DATA_WIDTH (ID_WIDTH + USER_WIDTH)
  ) u_id_fifo (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_w_inc     (ar_hs),
    .i_w_data    ({i_s_arid, i_s_aruser}),
    .o_w_full_n  (id_ready),
    .i_r_inc     (r_hs),
    .o_r_data    ({o_s_rid, o_s_ruser}),
    .o_r_empty_n (id_valid)
  );

  // Room in both queues also caps reads in flight
  assign o_s_arready = ar_ready && id_ready;

  // Return path passes straight through to the AXI side
  assign o_s_rvalid    = m_axil.rvalid;
  assign o_s_rdata     = m_axil.rdata;
  assign o_s_rresp     = m_axil.rresp;
  assign m_axil.rready = i_s_rready;

endmodule

`default_nettype wire

// File: src/axi_rd_pkg.sv
`default_nettype none

package axi_rd_pkg;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Default bus widths
  localparam int DEF_ADDR_WIDTH = 8;
  localparam int DEF_DATA_WIDTH = 16;
  localparam int DEF_ID_WIDTH   = 4;
  localparam int DEF_USER_WIDTH = 1;

  // log2 of reads in flight
  localparam int DEF_OUTSTANDING_BITS = 2;

  // Implemented words behind the AXI-Lite port
  localparam int DEF_MEM_WORDS = 32;

endpackage

`default_nettype wire

// File: src/axi_rd_top.sv
`timescale 1ns/100ps
`default_nettype none

module axi_rd_top #(
  parameter int ADDR_WIDTH       = axi_rd_pkg::DEF_ADDR_WIDTH,
  parameter int DATA_WIDTH       = axi_rd_pkg::DEF_DATA_WIDTH,
  parameter int ID_WIDTH         = axi_rd_pkg::DEF_ID_WIDTH,
  parameter int USER_WIDTH       = axi_rd_pkg::DEF_USER_WIDTH,
  parameter int OUTSTANDING_BITS = axi_rd_pkg::DEF_OUTSTANDING_BITS,
  parameter int MEM_WORDS        = axi_rd_pkg::DEF_MEM_WORDS
) (
  input  wire logic                  clk,
  input  wire logic                  i_rst,

  input  wire logic                  i_s_arvalid,
  input  wire logic [ID_WIDTH-1:0]   i_s_arid,
  input  wire logic [ADDR_WIDTH-1:0] i_s_araddr,
  input  wire logic [USER_WIDTH-1:0] i_s_aruser,
  output logic                       o_s_arready,
  output logic                       o_s_rvalid,
  output logic [ID_WIDTH-1:0]        o_s_rid,
  output logic [DATA_WIDTH-1:0]      o_s_rdata,
  output logic [1:0]                 o_s_rresp,
  output logic [USER_WIDTH-1:0]      o_s_ruser,
  input  wire logic                  i_s_rready
);
  // Internal AXI-Lite read link
  axil_rd_if #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) axil_bus ();

  axi_axil_reflect_rd #(
    .ADDR_WIDTH       (ADDR_WIDTH),
    .DATA_WIDTH       (DATA_WIDTH),
    .ID_WIDTH         (ID_WIDTH),
    .USER_WIDTH       (USER_WIDTH),
    .OUTSTANDING_BITS (OUTSTANDING_BITS)
  ) u_reflect (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_s_arvalid (i_s_arvalid),
    .i_s_arid    (i_s_arid),
    .i_s_araddr  (i_s_araddr),
    .i_s_aruser  (i_s_aruser),
    .o_s_arready (o_s_arready),
    .o_s_rvalid  (o_s_rvalid),
    .o_s_rid     (o_s_rid),
    .o_s_rdata   (o_s_rdata),
    .o_s_rresp   (o_s_rresp),
    .o_s_ruser   (o_s_ruser),
    .i_s_rready  (i_s_rready),
    .m_axil      (axil_bus.mgr)
  );

  axil_rd_mem #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .MEM_WORDS  (MEM_WORDS)
  ) u_mem (
    .clk    (clk),
    .i_rst  (i_rst),
    .s_axil (axil_bus.sub)
  );

endmodule

`default_nettype wire

// File: src/axil_rd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface axil_rd_if #(
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 16
);
  // Address channel
  logic                  arvalid;
  logic [ADDR_WIDTH-1:0] araddr;
  logic                  arready;

  // Read data channel
  logic                  rvalid;
  logic [DATA_WIDTH-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rready;

  modport mgr (output arvalid, araddr, rready, input arready, rvalid, rdata, rresp);

  modport sub (input arvalid, araddr, rready, output arready, rvalid, rdata, rresp);

endinterface

`default_nettype wire

// File: src/axil_rd_mem.sv
`timescale 1ns/100ps
`default_nettype none

module axil_rd_mem #(
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 16,
  parameter int MEM_WORDS  = 32
) (
  input  wire logic clk,
  input  wire logic i_rst,

  axil_rd_if.sub    s_axil
);
  import axi_rd_pkg::*;

  // Byte offset bits dropped from the address
  localparam int OFFSET_BITS  = $clog2(DATA_WIDTH / 8);
  localparam int IDX_BITS     = ADDR_WIDTH - OFFSET_BITS;
  localparam int MEM_IDX_BITS = $clog2(MEM_WORDS);

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

  logic [IDX_BITS-1:0]   word_idx;
  logic                  in_range;
  logic                  ar_hs;

  logic                  rvalid_q;
  logic [DATA_WIDTH-1:0] rdata_q;
  logic [1:0]            rresp_q;

  initial begin
    $readmemh("rom.hex", mem);
  end

  assign word_idx = s_axil.araddr[ADDR_WIDTH-1:OFFSET_BITS];
  assign in_range = (word_idx < IDX_BITS'(MEM_WORDS));
  assign ar_hs    = s_axil.arvalid && s_axil.arready;

  // One response held at a time
  assign s_axil.arready = !rvalid_q;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      rvalid_q <= 1'b0;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
    end else if (s_axil.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // Unmapped words read as zero with SLVERR
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata_q <= in_range ? mem[word_idx[MEM_IDX_BITS-1:0]] : '0;
      rresp_q <= in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign s_axil.rvalid = rvalid_q;
  assign s_axil.rdata  = rdata_q;
  assign s_axil.rresp  = rresp_q;

endmodule

`default_nettype wire

// File: src/sync_fifo_zl.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo_zl #(
  parameter int ADDR_BITS  = 1,
  parameter int DATA_WIDTH = 8
) (
  input  wire logic                  clk,
  input  wire logic                  i_rst,

  input  wire logic                  i_w_inc,
  input  wire logic [DATA_WIDTH-1:0] i_w_data,
  output logic                       o_w_full_n,

  input  wire logic                  i_r_inc,
  output logic [DATA_WIDTH-1:0]      o_r_data,
  output logic                       o_r_empty_n
);
  localparam int DEPTH = 2 ** ADDR_BITS;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Extra MSB tells full from empty
  logic [ADDR_BITS:0] w_ptr;
  logic [ADDR_BITS:0] r_ptr;

  logic empty;
  logic full;
  logic bypass;
  logic do_write;
  logic do_read;

  assign empty = (w_ptr == r_ptr);
  assign full  = (w_ptr[ADDR_BITS] != r_ptr[ADDR_BITS]) &&
                 (w_ptr[ADDR_BITS-1:0] == r_ptr[ADDR_BITS-1:0]);

  // Write lands on the read side the same cycle when empty
  assign bypass   = empty && i_w_inc && i_r_inc;
  assign do_write = i_w_inc && !full && !bypass;
  assign do_read  = i_r_inc && !empty;

  assign o_w_full_n  = !full;
  assign o_r_empty_n = !empty || i_w_inc;
  assign o_r_data    = empty ? i_w_data : mem[r_ptr[ADDR_BITS-1:0]];

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[w_ptr[ADDR_BITS-1:0]] <= i_w_data;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      if (do_write) begin
        w_ptr <= w_ptr + 1'b1;
      end
      if (do_read) begin
        r_ptr <= r_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/axi_rd_assert.sv
`timescale 1ns/100ps
`default_nettype none

module axi_rd_assert #(
  parameter int DATA_WIDTH = 16,
  parameter int ID_WIDTH   = 4,
  parameter int USER_WIDTH = 1
) (
  input  wire logic                  clk,
  input  wire logic                  i_rst,
  input  wire logic                  i_s_arready,
  input  wire logic                  i_s_rvalid,
  input  wire logic                  i_s_rready,
  input  wire logic [ID_WIDTH-1:0]   i_s_rid,
  input  wire logic [DATA_WIDTH-1:0] i_s_rdata,
  input  wire logic [1:0]            i_s_rresp,
  input  wire logic [USER_WIDTH-1:0] i_s_ruser,
  input  wire logic                  i_id_valid
);
  // Stalled return beat keeps valid and payload
  a_r_hold : assert property (@(posedge clk) disable iff (i_rst)
    i_s_rvalid && !i_s_rready |=>
      i_s_rvalid && $stable({i_s_rid, i_s_ruser, i_s_rresp, i_s_rdata}))
    else $error("read return changed while stalled");

  a_r_has_id : assert property (@(posedge clk) disable iff (i_rst)
    i_s_rvalid && i_s_rready |-> i_id_valid)
    else $error("read return taken while the ID queue was empty");

  a_ar_after_reset : assert property (@(posedge clk) $fell(i_rst) |-> i_s_arready)
    else $error("arready low in the first cycle after reset");

endmodule

bind axi_axil_reflect_rd axi_rd_assert #(
  .DATA_WIDTH (DATA_WIDTH),
  .ID_WIDTH   (ID_WIDTH),
  .USER_WIDTH (USER_WIDTH)
) u_assert (
  .clk         (clk),
  .i_rst       (i_rst),
  .i_s_arready (o_s_arready),
  .i_s_rvalid  (o_s_rvalid),
  .i_s_rready  (i_s_rready),
  .i_s_rid     (o_s_rid),
  .i_s_rdata   (o_s_rdata),
  .i_s_rresp   (o_s_rresp),
  .i_s_ruser   (o_s_ruser),
  .i_id_valid  (id_valid)
);

`default_nettype wire

// File: verif/tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker #(
  parameter int ADDR_WIDTH       = axi_rd_pkg::DEF_ADDR_WIDTH,
  parameter int DATA_WIDTH       = axi_rd_pkg::DEF_DATA_WIDTH,
  parameter int ID_WIDTH         = axi_rd_pkg::DEF_ID_WIDTH,
  parameter int USER_WIDTH       = axi_rd_pkg::DEF_USER_WIDTH,
  parameter int OUTSTANDING_BITS = axi_rd_pkg::DEF_OUTSTANDING_BITS,
  parameter int MEM_WORDS        = axi_rd_pkg::DEF_MEM_WORDS
) (
  input  wire logic                  clk,
  input  wire logic                  i_rst,
  input  wire logic                  i_arvalid,
  input  wire logic [ID_WIDTH-1:0]   i_arid,
  input  wire logic [ADDR_WIDTH-1:0] i_araddr,
  input  wire logic [USER_WIDTH-1:0] i_aruser,
  input  wire logic                  i_arready,
  input  wire logic                  i_rvalid,
  input  wire logic [ID_WIDTH-1:0]   i_rid,
  input  wire logic [DATA_WIDTH-1:0] i_rdata,
  input  wire logic [1:0]            i_rresp,
  input  wire logic [USER_WIDTH-1:0] i_ruser,
  input  wire logic                  i_rready,
  input  wire logic [2:0]            i_test_num,
  input  wire logic                  i_test_end,
  input  wire logic                  i_stall_check,
  input  wire logic                  i_report,
  output int                         o_pending,
  output int                         o_err_count
);
  import axi_rd_pkg::*;

  localparam int REQ_W = ADDR_WIDTH + ID_WIDTH + USER_WIDTH;
  localparam int RSP_W = ID_WIDTH + USER_WIDTH + 2 + DATA_WIDTH;
  // Two address slots plus the memory's held response, capped by the ID queue
  localparam int STALL_ACCEPTS = (2 ** OUTSTANDING_BITS < 3) ? 2 ** OUTSTANDING_BITS : 3;

  logic [DATA_WIDTH-1:0] rom [MEM_WORDS];
  logic [REQ_W-1:0]      req_q [$];
  logic                  rst_q = 1'b0;
  int                    test_checks;
  int                    test_errors;
  int                    all_checks;
  int                    all_errors;
  int                    n_tests;
  int                    accepts;

  initial begin
    $readmemh("rom.hex", rom);
  end

  function automatic string test_name(input logic [2:0] num);
    case (num)
      3'd0: return "reset";
      3'd1: return "single_reads";
      3'd2: return "random_stream";
      3'd3: return "out_of_range";
      3'd4: return "back_pressure";
      default: return "unknown";
    endcase
  endfunction

  // Expected {id, user, resp, data} for one request
  function automatic logic [RSP_W-1:0] expect_read(input logic [REQ_W-1:0] req);
    logic [ADDR_WIDTH-1:0] addr;
    logic [ID_WIDTH-1:0]   id;
    logic [USER_WIDTH-1:0] user;
    int                    idx;
    {addr, id, user} = req;
    idx = int'(addr) / (DATA_WIDTH / 8);
    if (idx < MEM_WORDS) begin
      return {id, user, RESP_OKAY, rom[idx]};
    end
    return {id, user, RESP_SLVERR, {DATA_WIDTH{1'b0}}};
  endfunction

  task automatic compare(input int exp, input int act, input string what);
    test_checks++;
    if (exp != act) begin
      test_errors++;
      $display("FAIL %s %s: expected %0h, got %0h", test_name(i_test_num), what, exp, act);
    end
  endtask

  always @(posedge clk) begin
    if (i_rst) begin
      req_q.delete();
      rst_q = 1'b1;
    end else begin
      if (rst_q) begin
        compare(0, int'(i_rvalid), "rvalid after reset");
        compare(1, int'(i_arready), "arready after reset");
      end
      rst_q = 1'b0;
      // Pop before push so a stray beat never matches a new request
      if (i_rvalid && i_rready) begin
        if (req_q.size() == 0) begin
          test_errors++;
          $display("ERROR %s: read data came back with no read outstanding",
                   test_name(i_test_num));
        end else begin
          compare(int'(expect_read(req_q.pop_front())),
                  int'({i_rid, i_ruser, i_rresp, i_rdata}), "read return");
        end
      end
      if (i_arvalid && i_arready) begin
        req_q.push_back({i_araddr, i_arid, i_aruser});
        accepts++;
      end
      if (i_stall_check) begin
        compare(STALL_ACCEPTS, accepts, "accepted reads");
        compare(0, int'(i_arready), "arready under back-pressure");
      end
      if (i_test_end) begin
        $display("%s: %0d checks, %0d errors", test_name(i_test_num), test_checks, test_errors);
        all_checks += test_checks;
        all_errors += test_errors;
        n_tests++;
        test_checks = 0;
        test_errors = 0;
        accepts = 0;
      end
      if (i_report) begin
        $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, all_checks, all_errors);
      end
    end
    o_pending   = req_q.size();
    o_err_count = all_errors + test_errors;
  end

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic o_clk
);
  initial begin
    o_clk = 1'b0;
  end

  always #(PERIOD_NS / 2.0) o_clk = ~o_clk;

endmodule

`default_nettype wire

// File: verif/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_top;
  import axi_rd_pkg::*;

  localparam int ADDR_WIDTH       = DEF_ADDR_WIDTH;
  localparam int DATA_WIDTH       = DEF_DATA_WIDTH;
  localparam int ID_WIDTH         = DEF_ID_WIDTH;
  localparam int USER_WIDTH       = DEF_USER_WIDTH;
  localparam int OUTSTANDING_BITS = DEF_OUTSTANDING_BITS;
  localparam int MEM_WORDS        = DEF_MEM_WORDS;

  localparam int STREAM_READS   = 64;
  localparam int OOR_READS      = 8;
  // Reset, single reads, stream, out of range and back-pressure
  localparam int TOTAL_READS    = 1 + MEM_WORDS + STREAM_READS + OOR_READS + 4;
  localparam int TIMEOUT_CYCLES = 200 * TOTAL_READS;

  localparam logic [ADDR_WIDTH-1:0] IN_RANGE_MASK = ADDR_WIDTH'(MEM_WORDS * (DATA_WIDTH / 8) - 1);
  localparam logic [ADDR_WIDTH-1:0] OOR_BASE      = ADDR_WIDTH'(MEM_WORDS * (DATA_WIDTH / 8));

  localparam logic [1:0] RDY_LOW    = 2'd0;
  localparam logic [1:0] RDY_HIGH   = 2'd1;
  localparam logic [1:0] RDY_RANDOM = 2'd2;

  logic                  clk;
  logic                  rst;
  logic                  arvalid;
  logic [ID_WIDTH-1:0]   arid;
  logic [ADDR_WIDTH-1:0] araddr;
  logic [USER_WIDTH-1:0] aruser;
  logic                  arready;
  logic                  rvalid;
  logic [ID_WIDTH-1:0]   rid;
  logic [DATA_WIDTH-1:0] rdata;
  logic [1:0]            rresp;
  logic [USER_WIDTH-1:0] ruser;
  logic                  rready = 1'b0;
  logic [1:0]            rready_mode;
  logic [2:0]            test_num;
  logic                  test_end;
  logic                  stall_check;
  logic                  report;
  int                    pending;
  int                    err_count;
  int                    seed = 589;
  // Own stream for the R side
  int                    ready_seed = 589;

  tb_clk_gen #(.PERIOD_NS (8.0)) u_clk_gen (.o_clk (clk));

  axi_rd_top #(
    .ADDR_WIDTH (ADDR_WIDTH), .DATA_WIDTH (DATA_WIDTH), .ID_WIDTH (ID_WIDTH),
    .USER_WIDTH (USER_WIDTH), .OUTSTANDING_BITS (OUTSTANDING_BITS), .MEM_WORDS (MEM_WORDS)
  ) u_dut (
    .clk (clk), .i_rst (rst),
    .i_s_arvalid (arvalid), .i_s_arid (arid), .i_s_araddr (araddr), .i_s_aruser (aruser),
    .o_s_arready (arready), .o_s_rvalid (rvalid), .o_s_rid (rid), .o_s_rdata (rdata),
    .o_s_rresp (rresp), .o_s_ruser (ruser), .i_s_rready (rready)
  );

  tb_checker #(
    .ADDR_WIDTH (ADDR_WIDTH), .DATA_WIDTH (DATA_WIDTH), .ID_WIDTH (ID_WIDTH),
    .USER_WIDTH (USER_WIDTH), .OUTSTANDING_BITS (OUTSTANDING_BITS), .MEM_WORDS (MEM_WORDS)
  ) u_checker (
    .clk (clk), .i_rst (rst),
    .i_arvalid (arvalid), .i_arid (arid), .i_araddr (araddr), .i_aruser (aruser),
    .i_arready (arready), .i_rvalid (rvalid), .i_rid (rid), .i_rdata (rdata),
    .i_rresp (rresp), .i_ruser (ruser), .i_rready (rready),
    .i_test_num (test_num), .i_test_end (test_end), .i_stall_check (stall_check),
    .i_report (report), .o_pending (pending), .o_err_count (err_count)
  );

  always @(negedge clk) begin
    case (rready_mode)
      RDY_HIGH:   rready = 1'b1;
      RDY_RANDOM: rready = ($random(ready_seed) & 1) != 0;
      default:    rready = 1'b0;
    endcase
  end

  task automatic drive_read(input logic [ADDR_WIDTH-1:0] addr, input logic [ID_WIDTH-1:0] id,
                            input logic [USER_WIDTH-1:0] user);
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = addr;
    arid    = id;
    aruser  = user;
  endtask

  // Returns on the rising edge that takes the request
  task automatic wait_accept();
    do begin
      @(posedge clk);
    end while (!arready);
  endtask

  task automatic random_read(input logic [ADDR_WIDTH-1:0] addr);
    int rnd;
    rnd = $random(seed);
    drive_read(addr, rnd[ID_WIDTH-1:0], rnd[ID_WIDTH+USER_WIDTH-1:ID_WIDTH]);
    wait_accept();
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      arvalid = 1'b0;
    end
  endtask

  task automatic finish_test();
    idle(1);
    while (pending != 0) begin
      @(negedge clk);
    end
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
    test_num = test_num + 3'd1;
  endtask

  initial begin
    int                    rnd;
    int                    waited;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  stalled;
    rst         = 1'b1;
    arvalid     = 1'b0;
    arid        = '0;
    araddr      = '0;
    aruser      = '0;
    rready_mode = RDY_LOW;
    test_num    = 3'd0;
    test_end    = 1'b0;
    stall_check = 1'b0;
    report      = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    finish_test();

    // One read at a time to every implemented word
    rready_mode = RDY_HIGH;
    for (int i = 0; i < MEM_WORDS; i++) begin
      random_read(ADDR_WIDTH'(i * (DATA_WIDTH / 8)));
      idle(1);
      while (pending != 0) begin
        @(negedge clk);
      end
    end
    finish_test();

    rready_mode = RDY_RANDOM;
    for (int i = 0; i < STREAM_READS; i++) begin
      rnd  = $random(seed);
      addr = rnd[ADDR_WIDTH-1:0];
      // About half the stream stays inside the memory
      if (rnd[ADDR_WIDTH]) begin
        addr = addr & IN_RANGE_MASK;
      end
      random_read(addr);
      idle(int'(rnd[ADDR_WIDTH+2:ADDR_WIDTH+1]));
    end
    rready_mode = RDY_HIGH;
    finish_test();

    for (int i = 0; i < OOR_READS; i++) begin
      rnd = $random(seed);
      random_read(OOR_BASE | rnd[ADDR_WIDTH-1:0]);
    end
    finish_test();

    // Keep issuing until a request sits unaccepted for 8 cycles
    rready_mode = RDY_LOW;
    stalled     = 1'b0;
    while (!stalled) begin
      rnd = $random(seed);
      drive_read(rnd[ADDR_WIDTH-1:0] & IN_RANGE_MASK, rnd[ID_WIDTH+7:8],
                 rnd[ID_WIDTH+USER_WIDTH+7:ID_WIDTH+8]);
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
      end while (!arready && waited < 8);
      stalled = !arready;
    end
    @(negedge clk);
    stall_check = 1'b1;
    @(negedge clk);
    stall_check = 1'b0;
    rready_mode = RDY_HIGH;
    wait_accept();
    finish_test();

    @(negedge clk);
    report = 1'b1;
    @(negedge clk);
    report = 1'b0;
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles while waiting on the DUT", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
